// File: Bender.yml
package:
  name: exec_stage

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - uarch_pkg.sv
      - wb_pkg.sv
      - exec_dispatch.sv
      - exec_alu.sv
      - exec_mul.sv
      - wb_arbiter.sv
      - exec_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_exec.sv

// File: all.f
+incdir+.
uarch_pkg.sv
wb_pkg.sv
exec_dispatch.sv
exec_alu.sv
exec_mul.sv
wb_arbiter.sv
exec_top.sv
tb_exec.sv

// File: exec_alu.sv
/*
 * single-cycle alu execute unit
 * one-entry input register, add/sub/logic/shift/compare datapath
 */

`timescale 1ns/1ps

module exec_alu (
  input  logic             clk,
  input  logic             rst,

  input  logic             in_val,
  output logic             in_rdy,
  input  uarch_pkg::rv_uop in_uop,
  input  wb_pkg::seq_num_t in_seq_num,
  input  wb_pkg::data_t    in_op1,
  input  wb_pkg::data_t    in_op2,
  input  wb_pkg::raddr_t   in_waddr,

  output logic             out_val,
  input  logic             out_rdy,
  output wb_pkg::seq_num_t out_seq_num,
  output wb_pkg::raddr_t   out_waddr,
  output wb_pkg::data_t    out_wdata
);

  // ------------------------------------------------------------------------
  // input register
  // ------------------------------------------------------------------------

  logic             full;     // entry holds a live op
  uarch_pkg::rv_uop uop_q;
  wb_pkg::seq_num_t seq_q;
  wb_pkg::data_t    op1_q;
  wb_pkg::data_t    op2_q;
  wb_pkg::raddr_t   waddr_q;
  logic             in_xfer;
  logic             out_xfer;

  assign in_xfer  = in_val & in_rdy;
  assign out_xfer = out_val & out_rdy;

  // load wins over drain, so take and drain in one cycle
  always_ff @(posedge clk) begin
    if (rst)
      full <= 1'b0;
    else if (in_xfer)
      full <= 1'b1;
    else if (out_xfer)
      full <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (in_xfer) begin
      uop_q   <= in_uop;
      seq_q   <= in_seq_num;
      op1_q   <= in_op1;
      op2_q   <= in_op2;
      waddr_q <= in_waddr;
    end
  end

  assign in_rdy      = out_rdy | !full;   // free slot or draining this cycle
  assign out_val     = full;
  assign out_seq_num = seq_q;
  assign out_waddr   = waddr_q;

  // ------------------------------------------------------------------------
  // datapath
  // ------------------------------------------------------------------------

  logic [4:0] shamt;   // rv32 shifts use op2[4:0]

  assign shamt = op2_q[4:0];

  always_comb begin
    case (uop_q)
      uarch_pkg::OP_ADD:  out_wdata = op1_q + op2_q;
      uarch_pkg::OP_SUB:  out_wdata = op1_q - op2_q;
      uarch_pkg::OP_AND:  out_wdata = op1_q & op2_q;
      uarch_pkg::OP_OR:   out_wdata = op1_q | op2_q;
      uarch_pkg::OP_XOR:  out_wdata = op1_q ^ op2_q;
      uarch_pkg::OP_SLL:  out_wdata = op1_q << shamt;
      uarch_pkg::OP_SRL:  out_wdata = op1_q >> shamt;
      uarch_pkg::OP_SRA:  out_wdata = wb_pkg::data_t'($signed(op1_q) >>> shamt);
      uarch_pkg::OP_SLT:  out_wdata = wb_pkg::data_t'($signed(op1_q) < $signed(op2_q));
      uarch_pkg::OP_SLTU: out_wdata = wb_pkg::data_t'(op1_q < op2_q);
      default:            out_wdata = '0;   // mul never lands here
    endcase
  end

  // ------------------------------------------------------------------------
  // checks
  // ------------------------------------------------------------------------

  // result stays up until W takes it
  a_hold_result : assert property (@(posedge clk) disable iff (rst)
    out_val && !out_rdy |=> out_val)
    else $error("exec_alu: result dropped without transfer");

  // dispatcher keeps mul away from here
  a_no_mul : assert property (@(posedge clk) disable iff (rst)
    in_val |-> in_uop != uarch_pkg::OP_MUL)
    else $error("exec_alu: OP_MUL steered to alu");

endmodule

// File: exec_consts.svh
/*
 * execute stage width constants
 * data, sequence number and register address widths, multiplier iterations
 */

`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// operand / result width
`define EXEC_DATA_BITS 32

// sequence number carried from D to W
`define EXEC_SEQ_BITS 8

`define EXEC_RADDR_BITS 5   // x0..x31

// one multiplier bit per cycle
`define EXEC_MUL_ITERS `EXEC_DATA_BITS

`endif

// File: exec_dispatch.sv
/*
 * D side dispatcher
 * steers each decoded op to the alu or the multiplier
 */

`timescale 1ns/1ps

module exec_dispatch (
  input  logic             d_val,
  input  uarch_pkg::rv_uop d_uop,
  output logic             d_rdy,

  output logic             alu_val,
  input  logic             alu_rdy,

  output logic             mul_val,
  input  logic             mul_rdy
);

  uarch_pkg::exec_unit unit;   // target of the op at the head of D

  assign unit = uarch_pkg::unit_of(d_uop);

  // only the chosen unit sees val
  assign alu_val = d_val & (unit == uarch_pkg::UNIT_ALU);
  assign mul_val = d_val & (unit == uarch_pkg::UNIT_MUL);

  // busy mul only stalls D when a mul is at the head
  assign d_rdy = (unit == uarch_pkg::UNIT_MUL) ? mul_rdy : alu_rdy;

  // ------------------------------------------------------------------------
  // checks
  // ------------------------------------------------------------------------

  // decode must never hand over an unused encoding
  always_comb begin
    if (d_val) begin
      a_legal_uop : assert final (!$isunknown(d_uop) &&
                                  d_uop inside {[uarch_pkg::OP_ADD:uarch_pkg::OP_MUL]})
        else $error("exec_dispatch: illegal uop %0d", d_uop);
    end
  end

endmodule

// File: exec_mul.sv
/*
 * iterative multiplier execute unit
 * shift-and-add, one multiplier bit per cycle, low half of product
 */

`timescale 1ns/1ps

`include "exec_consts.svh"

module exec_mul (
  input  logic             clk,
  input  logic             rst,

  input  logic             in_val,
  output logic             in_rdy,
  input  uarch_pkg::rv_uop in_uop,
  input  wb_pkg::seq_num_t in_seq_num,
  input  wb_pkg::data_t    in_op1,
  input  wb_pkg::data_t    in_op2,
  input  wb_pkg::raddr_t   in_waddr,

  output logic             out_val,
  input  logic             out_rdy,
  output wb_pkg::seq_num_t out_seq_num,
  output wb_pkg::raddr_t   out_waddr,
  output wb_pkg::data_t    out_wdata
);

  localparam int CNT_BITS = $clog2(`EXEC_MUL_ITERS);
  localparam logic [CNT_BITS-1:0] LAST_ITER = CNT_BITS'(`EXEC_MUL_ITERS - 1);

  logic                busy;     // iterating
  logic                done;     // result waiting for W
  logic [CNT_BITS-1:0] cnt;
  wb_pkg::data_t       mcand;    // shifts left each step
  wb_pkg::data_t       mplier;   // shifts right, bit 0 is current
  wb_pkg::data_t       acc;
  wb_pkg::seq_num_t    seq_q;
  wb_pkg::raddr_t      waddr_q;
  logic                in_xfer;
  logic                out_xfer;

  assign in_xfer  = in_val & in_rdy;
  assign out_xfer = out_val & out_rdy;

  // ------------------------------------------------------------------------
  // control
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      done <= 1'b0;
      cnt  <= '0;
    end else if (in_xfer) begin
      busy <= 1'b1;
      cnt  <= '0;
    end else if (busy) begin
      cnt <= cnt + 1'b1;
      if (cnt == LAST_ITER) begin   // last bit consumed
        busy <= 1'b0;
        done <= 1'b1;
      end
    end else if (out_xfer) begin
      done <= 1'b0;
    end
  end

  // ------------------------------------------------------------------------
  // datapath
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (in_xfer) begin
      mcand   <= in_op1;
      mplier  <= in_op2;
      acc     <= '0;
      seq_q   <= in_seq_num;
      waddr_q <= in_waddr;
    end else if (busy) begin
      if (mplier[0])
        acc <= acc + mcand;   // wraps, only low half kept
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  assign in_rdy      = !busy & !done;   // idle and drained
  assign out_val     = done;
  assign out_seq_num = seq_q;
  assign out_waddr   = waddr_q;
  assign out_wdata   = acc;

  // ------------------------------------------------------------------------
  // checks
  // ------------------------------------------------------------------------

  // no second op taken during the iteration window
  a_busy_window : assert property (@(posedge clk) disable iff (rst)
    in_xfer |=> !in_xfer [*`EXEC_MUL_ITERS])
    else $error("exec_mul: op accepted while busy");

  a_mul_only : assert property (@(posedge clk) disable iff (rst)
    in_val |-> in_uop == uarch_pkg::OP_MUL)
    else $error("exec_mul: non-mul uop steered to multiplier");

endmodule

// File: exec_top.sv
/*
 * execute stage top level
 * dispatcher, alu, multiplier and writeback arbiter
 */

`timescale 1ns/1ps

module exec_top (
  input  logic             clk,
  input  logic             rst,

  // D side
  input  logic             d_val,
  output logic             d_rdy,
  input  uarch_pkg::rv_uop d_uop,
  input  wb_pkg::seq_num_t d_seq_num,
  input  wb_pkg::data_t    d_op1,
  input  wb_pkg::data_t    d_op2,
  input  wb_pkg::raddr_t   d_waddr,

  // W side
  output logic             w_val,
  input  logic             w_rdy,
  output wb_pkg::seq_num_t w_seq_num,
  output wb_pkg::raddr_t   w_waddr,
  output wb_pkg::data_t    w_wdata,
  output logic             w_wen
);

  logic             alu_val, alu_rdy, mul_val, mul_rdy;
  logic             alu_res_val, alu_res_rdy;   // alu -> arbiter
  wb_pkg::seq_num_t alu_res_seq;
  wb_pkg::raddr_t   alu_res_waddr;
  wb_pkg::data_t    alu_res_wdata;
  logic             mul_res_val, mul_res_rdy;   // mul -> arbiter
  wb_pkg::seq_num_t mul_res_seq;
  wb_pkg::raddr_t   mul_res_waddr;
  wb_pkg::data_t    mul_res_wdata;

  exec_dispatch u_dispatch (
    .d_val(d_val), .d_uop(d_uop), .d_rdy(d_rdy),
    .alu_val(alu_val), .alu_rdy(alu_rdy),
    .mul_val(mul_val), .mul_rdy(mul_rdy)
  );

  exec_alu u_alu (
    .clk(clk), .rst(rst),
    .in_val(alu_val), .in_rdy(alu_rdy), .in_uop(d_uop), .in_seq_num(d_seq_num),
    .in_op1(d_op1), .in_op2(d_op2), .in_waddr(d_waddr),
    .out_val(alu_res_val), .out_rdy(alu_res_rdy), .out_seq_num(alu_res_seq),
    .out_waddr(alu_res_waddr), .out_wdata(alu_res_wdata)
  );

  exec_mul u_mul (
    .clk(clk), .rst(rst),
    .in_val(mul_val), .in_rdy(mul_rdy), .in_uop(d_uop), .in_seq_num(d_seq_num),
    .in_op1(d_op1), .in_op2(d_op2), .in_waddr(d_waddr),
    .out_val(mul_res_val), .out_rdy(mul_res_rdy), .out_seq_num(mul_res_seq),
    .out_waddr(mul_res_waddr), .out_wdata(mul_res_wdata)
  );

  // alu on port a, so it wins the first tie after reset
  wb_arbiter u_arb (
    .clk(clk), .rst(rst),
    .a_val(alu_res_val), .a_rdy(alu_res_rdy), .a_seq_num(alu_res_seq),
    .a_waddr(alu_res_waddr), .a_wdata(alu_res_wdata),
    .b_val(mul_res_val), .b_rdy(mul_res_rdy), .b_seq_num(mul_res_seq),
    .b_waddr(mul_res_waddr), .b_wdata(mul_res_wdata),
    .w_val(w_val), .w_rdy(w_rdy), .w_seq_num(w_seq_num),
    .w_waddr(w_waddr), .w_wdata(w_wdata), .w_wen(w_wen)
  );

endmodule

// File: tb_exec.sv
/*
 * testbench for the execute stage
 * corner sweep, alu/mul overlap check, random traffic with W back-pressure
 */

`timescale 1ns/1ps

`include "exec_consts.svh"

module tb_exec;

  localparam int NUM_CORNERS  = 6;
  localparam int NUM_RANDOM   = 300;
  localparam int NUM_OPS      = 11 * NUM_CORNERS * NUM_CORNERS + 5 + NUM_RANDOM;
  localparam int MAX_CYCLES   = 50 * NUM_OPS + 200;
  localparam int SEQ_SLOTS    = 1 << `EXEC_SEQ_BITS;
  localparam int DRAIN_CYCLES = 200;   // last results under W stalls

  logic             clk;
  logic             rst;
  logic             d_val;
  logic             d_rdy;
  uarch_pkg::rv_uop d_uop;
  wb_pkg::seq_num_t d_seq_num;
  wb_pkg::data_t    d_op1;
  wb_pkg::data_t    d_op2;
  wb_pkg::raddr_t   d_waddr;
  logic             w_val;
  logic             w_rdy;
  logic             w_wen;
  wb_pkg::seq_num_t w_seq_num;
  wb_pkg::raddr_t   w_waddr;
  wb_pkg::data_t    w_wdata;

  // scoreboard, one slot per sequence number
  wb_pkg::data_t    exp_data   [SEQ_SLOTS];
  wb_pkg::raddr_t   exp_waddr  [SEQ_SLOTS];
  logic             pending    [SEQ_SLOTS];
  int               arrive_idx [SEQ_SLOTS];   // order seen at W

  int               errors      = 0;
  int               pending_cnt = 0;
  int               issued      = 0;
  int               results     = 0;
  int               cycles;
  wb_pkg::seq_num_t next_seq    = '0;
  wb_pkg::seq_num_t last_seq;
  logic [31:0]      stim_state  = 32'he6aa_3493;
  logic [31:0]      bp_state    = 32'he6aa_3493 ^ 32'h5a5a_5a5a;   // own stream for w_rdy
  logic             bp_on       = 1'b0;
  logic             d_started   = 1'b0;   // first D transfer seen
  logic             prev_stall  = 1'b0;
  wb_pkg::seq_num_t held_seq;
  wb_pkg::raddr_t   held_waddr;
  wb_pkg::data_t    held_data;
  logic             held_wen;

  exec_top uut (
    .clk(clk), .rst(rst),
    .d_val(d_val), .d_rdy(d_rdy), .d_uop(d_uop), .d_seq_num(d_seq_num),
    .d_op1(d_op1), .d_op2(d_op2), .d_waddr(d_waddr),
    .w_val(w_val), .w_rdy(w_rdy), .w_seq_num(w_seq_num),
    .w_waddr(w_waddr), .w_wdata(w_wdata), .w_wen(w_wen)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;   // 8 ns period
  end

  // --------------------------------------------------------------------------
  // random source and reference model
  // --------------------------------------------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    stim_state = xorshift32(stim_state);
    return stim_state;
  endfunction

  function automatic wb_pkg::data_t corner_value(input int i);
    case (i)
      0:       return 32'h0;
      1:       return 32'h1;
      2:       return 32'h1f;          // largest shift
      3:       return 32'h7fff_ffff;   // max signed
      4:       return 32'h8000_0000;   // min signed
      default: return 32'hffff_ffff;
    endcase
  endfunction

  // mostly random, one in eight from the corner table
  function automatic wb_pkg::data_t pick_operand();
    logic [31:0] r;
    r = next_rand();
    if (r[2:0] == 3'd0)
      return corner_value(int'(r[10:8]) % NUM_CORNERS);
    return next_rand();
  endfunction

  // rv32 semantics for the low result word
  function automatic wb_pkg::data_t ref_result(input uarch_pkg::rv_uop uop,
                                               input wb_pkg::data_t a,
                                               input wb_pkg::data_t b);
    logic [4:0]  sh;
    logic [63:0] prod;
    sh   = b[4:0];
    prod = {32'b0, a} * {32'b0, b};
    case (uop)
      uarch_pkg::OP_ADD:  return a + b;
      uarch_pkg::OP_SUB:  return a + ~b + 32'd1;   // two's complement
      uarch_pkg::OP_AND:  return a & b;
      uarch_pkg::OP_OR:   return a | b;
      uarch_pkg::OP_XOR:  return a ^ b;
      uarch_pkg::OP_SLL:  return a << sh;
      uarch_pkg::OP_SRL:  return a >> sh;
      uarch_pkg::OP_SRA:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
      uarch_pkg::OP_SLT:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
      uarch_pkg::OP_SLTU: return {31'b0, a < b};
      uarch_pkg::OP_MUL:  return prod[31:0];
      default:            return 'x;
    endcase
  endfunction

  // --------------------------------------------------------------------------
  // D driver tasks
  // --------------------------------------------------------------------------

  // drive one op and wait until D takes it
  task automatic send_op(input uarch_pkg::rv_uop uop, input wb_pkg::data_t a,
                         input wb_pkg::data_t b, input wb_pkg::raddr_t rd);
    @(posedge clk);
    if (pending[next_seq]) begin
      $display("sequence number %0d reused while still outstanding", next_seq);
      errors++;
    end
    exp_data[next_seq]  = ref_result(uop, a, b);
    exp_waddr[next_seq] = rd;
    pending[next_seq]   = 1'b1;
    pending_cnt++;
    d_val     <= 1'b1;
    d_uop     <= uop;
    d_seq_num <= next_seq;
    d_op1     <= a;
    d_op2     <= b;
    d_waddr   <= rd;
    last_seq = next_seq;
    next_seq++;
    @(negedge clk);
    while (!d_rdy)
      @(negedge clk);   // payload held meanwhile
    d_started = 1'b1;
    issued++;
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    d_val <= 1'b0;
  endtask

  // leftovers after the wait show up in the final pending scan
  task automatic drain();
    int waited;
    waited = 0;
    idle_cycle();
    while (pending_cnt != 0 && waited < DRAIN_CYCLES) begin
      @(negedge clk);
      waited++;
    end
  endtask

  // w_rdy about 70% high when back-pressure is on
  always @(posedge clk) begin
    if (bp_on) begin
      bp_state = xorshift32(bp_state);
      w_rdy <= (bp_state % 10) < 7;
    end else begin
      w_rdy <= 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // W monitor and scoreboard
  // --------------------------------------------------------------------------

  task automatic check_result();
    if (!pending[w_seq_num]) begin
      $display("FAIL @%0t: result for seq %0d with nothing outstanding", $time, w_seq_num);
      errors++;
    end else begin
      if (w_wdata !== exp_data[w_seq_num]) begin
        $display("FAIL @%0t: seq %0d data %h, expected %h", $time, w_seq_num, w_wdata,
                 exp_data[w_seq_num]);
        errors++;
      end
      if (w_waddr !== exp_waddr[w_seq_num]) begin
        $display("FAIL @%0t: seq %0d waddr %0d, expected %0d", $time, w_seq_num, w_waddr,
                 exp_waddr[w_seq_num]);
        errors++;
      end
      if (w_wen !== (exp_waddr[w_seq_num] != 5'd0)) begin   // x0 never written
        $display("FAIL @%0t: seq %0d wen %b for waddr %0d", $time, w_seq_num, w_wen,
                 exp_waddr[w_seq_num]);
        errors++;
      end
      pending[w_seq_num] = 1'b0;
      pending_cnt--;
    end
    arrive_idx[w_seq_num] = results;
    results++;
  endtask

  // samples W mid-cycle ahead of the transfer edge
  always @(negedge clk) begin
    if (!rst) begin
      if (w_val && !d_started) begin
        $display("W went valid before any operation was sent, at %0t", $time);
        errors++;
      end
      if (prev_stall && (!w_val || w_seq_num !== held_seq || w_waddr !== held_waddr ||
                         w_wdata !== held_data || w_wen !== held_wen)) begin
        $display("FAIL @%0t: W fields changed while stalled, seq %0d", $time, held_seq);
        errors++;
      end
      if (w_val && w_rdy)
        check_result();
      prev_stall = w_val && !w_rdy;
      held_seq   = w_seq_num;
      held_waddr = w_waddr;
      held_data  = w_wdata;
      held_wen   = w_wen;
    end
  end

  // --------------------------------------------------------------------------
  // test sequence
  // --------------------------------------------------------------------------

  initial begin
    wb_pkg::seq_num_t mul_seq;
    wb_pkg::seq_num_t alu_seq [4];
    logic [31:0]      r;
    rst       = 1'b1;
    d_val     = 1'b0;
    d_uop     = uarch_pkg::OP_ADD;
    d_seq_num = '0;
    d_op1     = '0;
    d_op2     = '0;
    d_waddr   = '0;
    w_rdy     = 1'b0;
    for (int s = 0; s < SEQ_SLOTS; s++) begin
      pending[s]    = 1'b0;
      arrive_idx[s] = 0;
    end
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    repeat (8) @(posedge clk);   // W must stay quiet here

    // every uop against every pair of corner operands
    for (int u = 0; u <= int'(uarch_pkg::OP_MUL); u++)
      for (int i = 0; i < NUM_CORNERS; i++)
        for (int j = 0; j < NUM_CORNERS; j++)
          send_op(uarch_pkg::rv_uop'(4'(u)), corner_value(i), corner_value(j),
                  wb_pkg::raddr_t'(u + i + j));
    drain();

    // alu ops behind a busy multiply overtake it
    send_op(uarch_pkg::OP_MUL, next_rand(), next_rand(), 5'd9);
    mul_seq = last_seq;
    for (int k = 0; k < 4; k++) begin
      send_op(uarch_pkg::rv_uop'(4'(k)), next_rand(), next_rand(), wb_pkg::raddr_t'(k + 1));
      alu_seq[k] = last_seq;
    end
    drain();
    for (int k = 0; k < 4; k++)
      if (arrive_idx[alu_seq[k]] > arrive_idx[mul_seq]) begin
        $display("FAIL @%0t: alu seq %0d reached W after the multiply", $time, alu_seq[k]);
        errors++;
      end

    // random mix under back-pressure
    bp_on = 1'b1;
    for (int n = 0; n < NUM_RANDOM; n++) begin
      r = next_rand();
      if (r[31:29] == 3'b000)
        idle_cycle();   // occasional gap on D
      send_op(uarch_pkg::rv_uop'(4'(r % 11)), pick_operand(), pick_operand(),
              wb_pkg::raddr_t'(r[12:8]));
    end
    drain();
    repeat (4) @(posedge clk);

    for (int s = 0; s < SEQ_SLOTS; s++)
      if (pending[s]) begin
        $display("seq %0d never came back at W", s);
        errors++;
      end
    $display("errors: %0d  sent: %0d  results: %0d", errors, issued, results);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

  // run limit from the op count
  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// File: uarch_pkg.sv
/*
 * instruction-set view of the execute stage
 * uop encoding, execute unit select and the uop to unit map
 */

package uarch_pkg;

  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_SLL  = 4'd5,
    OP_SRL  = 4'd6,
    OP_SRA  = 4'd7,
    OP_SLT  = 4'd8,
    OP_SLTU = 4'd9,
    OP_MUL  = 4'd10   // last legal code, 11..15 unused
  } rv_uop;

  typedef enum logic {
    UNIT_ALU = 1'b0,
    UNIT_MUL = 1'b1
  } exec_unit;

  // only mul leaves the alu
  function automatic exec_unit unit_of(rv_uop uop);
    return (uop == OP_MUL) ? UNIT_MUL : UNIT_ALU;
  endfunction

endpackage

// File: wb_arbiter.sv
/*
 * writeback arbiter
 * round-robin merge of alu (a) and mul (b) results, x0 write suppression
 */

`timescale 1ns/1ps

module wb_arbiter (
  input  logic             clk,
  input  logic             rst,

  input  logic             a_val,
  output logic             a_rdy,
  input  wb_pkg::seq_num_t a_seq_num,
  input  wb_pkg::raddr_t   a_waddr,
  input  wb_pkg::data_t    a_wdata,

  input  logic             b_val,
  output logic             b_rdy,
  input  wb_pkg::seq_num_t b_seq_num,
  input  wb_pkg::raddr_t   b_waddr,
  input  wb_pkg::data_t    b_wdata,

  output logic             w_val,
  input  logic             w_rdy,
  output wb_pkg::seq_num_t w_seq_num,
  output wb_pkg::raddr_t   w_waddr,
  output wb_pkg::data_t    w_wdata,
  output logic             w_wen
);

  logic prio_b;   // b wins a tie
  logic hold;     // W stalled last cycle, grant frozen
  logic hold_b;
  logic sel_b;
  logic w_xfer;

  // frozen grant keeps W fields steady under back-pressure
  always_comb begin
    if (hold)
      sel_b = hold_b;
    else
      sel_b = b_val & (!a_val | prio_b);
  end

  assign w_val     = a_val | b_val;
  assign w_seq_num = sel_b ? b_seq_num : a_seq_num;
  assign w_waddr   = sel_b ? b_waddr   : a_waddr;
  assign w_wdata   = sel_b ? b_wdata   : a_wdata;
  assign w_wen     = (w_waddr != '0);   // x0 is never written

  assign a_rdy  = w_rdy & a_val & !sel_b;
  assign b_rdy  = w_rdy & b_val & sel_b;
  assign w_xfer = w_val & w_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      prio_b <= 1'b0;   // alu first
      hold   <= 1'b0;
      hold_b <= 1'b0;
    end else begin
      if (w_xfer)
        prio_b <= !sel_b;   // last winner loses next tie
      hold <= w_val & !w_rdy;
      if (w_val & !w_rdy)
        hold_b <= sel_b;
    end
  end

  // ------------------------------------------------------------------------
  // checks
  // ------------------------------------------------------------------------

  a_one_rdy : assert property (@(posedge clk) disable iff (rst)
    !(a_rdy && b_rdy))
    else $error("wb_arbiter: both units granted");

  // relies on the units holding their results while stalled
  a_w_stable : assert property (@(posedge clk) disable iff (rst)
    w_val && !w_rdy |=> w_val && $stable(w_seq_num) && $stable(w_wdata))
    else $error("wb_arbiter: W changed under back-pressure");

endmodule

// File: wb_pkg.sv
/*
 * field types of a writeback record
 * sequence number, destination register and result data
 */

`include "exec_consts.svh"

package wb_pkg;

  // tags each op so out-of-order results can be matched
  typedef logic [`EXEC_SEQ_BITS-1:0] seq_num_t;

  typedef logic [`EXEC_RADDR_BITS-1:0] raddr_t;   // rd

  typedef logic [`EXEC_DATA_BITS-1:0] data_t;

endpackage
